// ==== build.f ====
+incdir+common
common/sync_pkg.sv
common/axil_rd_if.sv
src/sync/sync_event.sv
src/sync/sync_bus.sv
src/status_regs.sv
src/axil_read_slave.sv
src/cdc_reg_reader.sv
verification/tb_cdc_reg_reader.sv

// ==== verification/tb_cdc_reg_reader.sv ====
// ======================================================================
// Random testbench for cdc_reg_reader, runs the build's handshake mode
// clk_in stimulus changes only between reads, then settles 10 cycles
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "sync_macros.svh"

module tb_cdc_reg_reader
    import sync_pkg::*;
();

    // Read counts per test
    localparam int ID_READS   = 1;
    localparam int EVT_ROUNDS = 6;
    localparam int CNT_READS  = 8;
    localparam int ERR_READS  = 20;
    localparam int BP_READS   = 20;
    localparam int BP_BURSTS  = BP_READS / 5;
    localparam int NUM_READS  = ID_READS + 2 * EVT_ROUNDS + CNT_READS + ERR_READS + BP_READS;

    // Timing budget in cycles
    localparam int ROUND_TRIP_CYC = 40;
    localparam int SHORT_STALL    = 3;
    localparam int MAX_STALL      = 12;
    localparam int MAX_BURST      = 32;
    localparam int SETTLE_CYC     = 10;
    localparam int AR_LIMIT       = 2 * ROUND_TRIP_CYC;
    localparam int RESP_LIMIT     = ROUND_TRIP_CYC + MAX_STALL + 10;

    // Reads plus event bursts plus reset, with margin
    localparam int BURST_NS    = (MAX_BURST + SETTLE_CYC + 2) * 14;
    localparam int WATCHDOG_NS = NUM_READS * (ROUND_TRIP_CYC + MAX_STALL) * 10
                               + (EVT_ROUNDS + BP_BURSTS) * BURST_NS + 2500;

    logic       clk_out = 1'b0;
    logic       clk_in  = 1'b0;
    logic       rst_out;
    logic       rst_in;
    logic       evt_pulse;
    data_t      status_in;
    addr_t      s_axil_araddr;
    logic       s_axil_arvalid;
    logic       s_axil_arready;
    data_t      s_axil_rdata;
    axil_resp_t s_axil_rresp;
    logic       s_axil_rvalid;
    logic       s_axil_rready;

    // Register model
    data_t model_evt_cnt;
    data_t model_status;
    data_t model_reads;

    // Bookkeeping
    logic [31:0] rng_state;
    int          test_num;
    int          test_errors;
    int          error_count;
    int          check_count;

    // Unrelated periods, 10 ns host and 14 ns registers
    always #5 clk_out = ~clk_out;
    always #7 clk_in  = ~clk_in;

    cdc_reg_reader dut0 (
        .clk_out        (clk_out),
        .rst_out        (rst_out),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .evt_pulse      (evt_pulse),
        .status_in      (status_in)
    );

    // LCG step, upper bits only since the low ones repeat quickly
    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return (rng_state >> 8) % n;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            test_errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        test_errors++;
        $display("error: %s", what);
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %s, %0d errors", test_num, name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        test_errors = 0;
    endtask

    // Expected response from the register map
    task automatic predict_read(input addr_t addr, output data_t exp_data,
                                output axil_resp_t exp_resp);
        exp_resp = AXIL_RESP_OKAY;
        if (addr >= `SYNC_NUM_REGS) begin
            exp_data = '0;
            exp_resp = AXIL_RESP_SLVERR;
        end else if (addr == 0) begin
            exp_data = `SYNC_REG_ID;
        end else if (addr == 1) begin
            exp_data = model_evt_cnt;
        end else if (addr == 2) begin
            exp_data = model_status;
        end else begin
            // Reads served before this one
            exp_data = model_reads;
        end
    endtask

    // Random evt_pulse burst, new status, then settle
    task automatic drive_events(input int cycles);
        logic        pulse;
        int unsigned hi;
        int unsigned lo;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_in);
            pulse = (rand_below(4) != 0);
            evt_pulse <= pulse;
            if (pulse) begin
                model_evt_cnt = model_evt_cnt + 1;
            end
        end
        hi = rand_below(65536);
        lo = rand_below(65536);
        @(posedge clk_in);
        evt_pulse    <= 1'b0;
        status_in    <= {hi[15:0], lo[15:0]};
        model_status = {hi[15:0], lo[15:0]};
        repeat (SETTLE_CYC) @(posedge clk_in);
    endtask

    // One full AXI4-Lite read with a random rready stall
    task automatic axil_read(input addr_t addr, input int max_stall, output data_t got_data);
        data_t      exp_data;
        axil_resp_t exp_resp;
        data_t      first_data;
        axil_resp_t first_resp;
        logic       seen_rvalid;
        logic       done;
        int         wait_cyc;
        int         stall_left;
        predict_read(addr, exp_data, exp_resp);
        stall_left = rand_below(max_stall + 1);
        got_data   = '0;
        first_data = '0;
        first_resp = AXIL_RESP_OKAY;
        @(posedge clk_out);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        s_axil_rready  <= 1'b0;
        // Address phase, nothing may come back yet
        wait_cyc = 0;
        done     = 1'b0;
        while (!done) begin
            @(posedge clk_out);
            wait_cyc++;
            check_value("s_axil_rvalid", s_axil_rvalid, 1'b0);
            if (s_axil_arready) begin
                done = 1'b1;
            end else if (wait_cyc > AR_LIMIT) begin
                report_failure($sformatf("read of address %0h was never accepted", addr));
                s_axil_arvalid <= 1'b0;
                return;
            end
        end
        s_axil_arvalid <= 1'b0;
        s_axil_rready  <= (stall_left == 0);
        // Data phase, arready low and R held until the handshake
        wait_cyc    = 0;
        done        = 1'b0;
        seen_rvalid = 1'b0;
        while (!done) begin
            @(posedge clk_out);
            wait_cyc++;
            check_value("s_axil_arready", s_axil_arready, 1'b0);
            if (!seen_rvalid) begin
                if (s_axil_rvalid) begin
                    seen_rvalid = 1'b1;
                    first_data  = s_axil_rdata;
                    first_resp  = s_axil_rresp;
                end
            end else begin
                check_value("s_axil_rvalid", s_axil_rvalid, 1'b1);
                check_value("s_axil_rdata", s_axil_rdata, first_data);
                check_value("s_axil_rresp", s_axil_rresp, first_resp);
            end
            if (seen_rvalid && s_axil_rready) begin
                done = 1'b1;
            end else if (seen_rvalid) begin
                if (stall_left > 0) begin
                    stall_left--;
                end
                if (stall_left == 0) begin
                    s_axil_rready <= 1'b1;
                end
            end else if (wait_cyc > RESP_LIMIT) begin
                report_failure($sformatf("no response for read of address %0h", addr));
                return;
            end
        end
        s_axil_rready <= 1'b0;
        check_value("s_axil_rdata", first_data, exp_data);
        check_value("s_axil_rresp", first_resp, exp_resp);
        got_data    = first_data;
        model_reads = model_reads + 1;
        // One response per read
        @(posedge clk_out);
        check_value("s_axil_rvalid", s_axil_rvalid, 1'b0);
    endtask

    initial begin
        data_t rd;
        data_t prev;
        addr_t addr;
        rng_state      = 32'h41fb47d8;
        test_num       = 0;
        test_errors    = 0;
        error_count    = 0;
        check_count    = 0;
        model_evt_cnt  = '0;
        model_status   = '0;
        model_reads    = '0;
        rst_out        = 1'b1;
        rst_in         = 1'b1;
        evt_pulse      = 1'b0;
        status_in      = '0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;

        // Each reset held 10 cycles of its own clock
        fork
            begin
                repeat (10) @(posedge clk_out);
                rst_out <= 1'b0;
            end
            begin
                repeat (10) @(posedge clk_in);
                rst_in <= 1'b0;
            end
        join
        repeat (4) @(posedge clk_out);

        // Idle bus, then the ID register
        check_value("s_axil_rvalid", s_axil_rvalid, 1'b0);
        check_value("s_axil_arready", s_axil_arready, 1'b1);
        axil_read(addr_t'(0), SHORT_STALL, rd);
        end_test("reset and ID");

        for (int r = 0; r < EVT_ROUNDS; r++) begin
            drive_events(1 + rand_below(MAX_BURST));
            axil_read(addr_t'(1), SHORT_STALL, rd);
            axil_read(addr_t'(2), SHORT_STALL, rd);
        end
        end_test("event count and status");

        // Served count steps by one per read
        prev = '0;
        for (int i = 0; i < CNT_READS; i++) begin
            axil_read(addr_t'(3), SHORT_STALL, rd);
            if (i > 0) begin
                check_value("addr 3 step", rd, prev + 1);
            end
            prev = rd;
        end
        end_test("served read count");

        // Mostly unmapped, every third one mapped
        for (int i = 0; i < ERR_READS; i++) begin
            if (i % 3 == 2) begin
                addr = addr_t'(rand_below(`SYNC_NUM_REGS));
            end else begin
                addr = addr_t'(`SYNC_NUM_REGS + rand_below(16 - `SYNC_NUM_REGS));
            end
            axil_read(addr, SHORT_STALL, rd);
        end
        end_test("unmapped addresses");

        // Long stalls, register values moving between reads
        for (int i = 0; i < BP_READS; i++) begin
            if (i % 5 == 0) begin
                drive_events(1 + rand_below(MAX_BURST));
            end
            axil_read(addr_t'(rand_below(16)), MAX_STALL, rd);
        end
        end_test("back-pressure and ordering");

        $display("tests %0d, checks %0d, errors %0d", test_num, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog sized from the read count
    initial begin
        #(WATCHDOG_NS);
        $display("error: watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_cdc_reg_reader

`default_nettype wire

// ==== src/cdc_reg_reader.sv ====
// ==================================================================
// Top level, AXI4-Lite reads in clk_out of registers in clk_in
// Each reset must be synchronous to its own clock
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

`include "sync_macros.svh"

module cdc_reg_reader
    import sync_pkg::*;
#(
    parameter handshake_mode_t HANDSHAKE_MODE = `SYNC_HANDSHAKE_MODE
) (
    // Host domain
    input  logic       clk_out,
    input  logic       rst_out,
    input  addr_t      s_axil_araddr,
    input  logic       s_axil_arvalid,
    output logic       s_axil_arready,
    output data_t      s_axil_rdata,
    output axil_resp_t s_axil_rresp,
    output logic       s_axil_rvalid,
    input  logic       s_axil_rready,
    // Register domain
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       evt_pulse,
    input  data_t      status_in
);

    // Request path, clk_out side then clk_in side
    logic    req;
    addr_t   req_addr;
    logic    req_rdy;
    logic    req_ack;
    addr_t   req_addr_dst;

    // Response path, clk_in side then clk_out side
    logic    rsp_req;
    rd_rsp_t rsp_src;
    logic    rsp_rdy;
    logic    rsp_ack;
    rd_rsp_t rsp_dst;

    axil_rd_if axil0 ();

    // Plain ports onto the bus
    assign axil0.araddr   = s_axil_araddr;
    assign axil0.arvalid  = s_axil_arvalid;
    assign axil0.rready   = s_axil_rready;
    assign s_axil_arready = axil0.arready;
    assign s_axil_rdata   = axil0.rdata;
    assign s_axil_rresp   = axil0.rresp;
    assign s_axil_rvalid  = axil0.rvalid;

    axil_read_slave axil_slave0 (
        .clk_out  (clk_out),
        .rst_out  (rst_out),
        .axil     (axil0.slave),
        .req_rdy  (req_rdy),
        .req      (req),
        .req_addr (req_addr),
        .rsp_ack  (rsp_ack),
        .rsp      (rsp_dst)
    );

    // Address from clk_out to clk_in
    sync_bus #(
        .T              (addr_t),
        .RST_VALUE      ('0),
        .HANDSHAKE_MODE (HANDSHAKE_MODE)
    ) req_sync0 (
        .clk_in   (clk_out),
        .rst_in   (rst_out),
        .req_in   (req),
        .data_in  (req_addr),
        .rdy_in   (req_rdy),
        .clk_out  (clk_in),
        .rst_out  (rst_in),
        .ack_out  (req_ack),
        .data_out (req_addr_dst)
    );

    status_regs regs0 (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .evt_pulse (evt_pulse),
        .status_in (status_in),
        .req_ack   (req_ack),
        .req_addr  (req_addr_dst),
        .rsp_rdy   (rsp_rdy),
        .rsp_req   (rsp_req),
        .rsp       (rsp_src)
    );

    // Response from clk_in back to clk_out
    sync_bus #(
        .T              (rd_rsp_t),
        .RST_VALUE      ('0),
        .HANDSHAKE_MODE (HANDSHAKE_MODE)
    ) rsp_sync0 (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .req_in   (rsp_req),
        .data_in  (rsp_src),
        .rdy_in   (rsp_rdy),
        .clk_out  (clk_out),
        .rst_out  (rst_out),
        .ack_out  (rsp_ack),
        .data_out (rsp_dst)
    );

endmodule : cdc_reg_reader

`default_nettype wire

// ==== src/axil_read_slave.sv ====
// ==================================================================
// AXI4-Lite read slave in clk_out, one read outstanding
// arready also waits for the request crossing to re-arm
// err from the register side maps to SLVERR
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

module axil_read_slave
    import sync_pkg::*;
(
    input  logic    clk_out,
    input  logic    rst_out,
    axil_rd_if.slave axil,
    // Request crossing
    input  logic    req_rdy,
    output logic    req,
    output addr_t   req_addr,
    // Response crossing
    input  logic    rsp_ack,
    input  rd_rsp_t rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } state_t;

    state_t     state;
    data_t      rdata_q;
    axil_resp_t rresp_q;

    // Address taken only when idle and the crossing is armed
    assign axil.arready = (state == ST_IDLE) && req_rdy;

    // Launch straight from the AR handshake
    assign req      = axil.arvalid && axil.arready;
    assign req_addr = axil.araddr;

    // Read data channel
    assign axil.rvalid = (state == ST_RESP);
    assign axil.rdata  = rdata_q;
    assign axil.rresp  = rresp_q;

    always_ff @(posedge clk_out) begin
        if (rst_out) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rsp_ack) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // Hold until the host takes it
                    if (axil.rready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Response capture
    always_ff @(posedge clk_out) begin
        if (state == ST_WAIT && rsp_ack) begin
            rdata_q <= rsp.data;
            rresp_q <= rsp.err ? AXIL_RESP_SLVERR : AXIL_RESP_OKAY;
        end
    end

    // Host must hold AR until it is taken
    ar_hold: assert property (
        @(posedge clk_out) disable iff (rst_out)
        axil.arvalid && !axil.arready |=>
            axil.arvalid && $stable(axil.araddr)
    ) else $error("axil_read_slave: AR changed before acceptance");

    // Responses come back only for a launched read
    rsp_expected: assert property (
        @(posedge clk_out) disable iff (rst_out) rsp_ack |-> state == ST_WAIT
    ) else $error("axil_read_slave: response without a read in flight");

endmodule : axil_read_slave

`default_nettype wire

// ==== src/status_regs.sv ====
// ==================================================================
// clk_in status registers, read-only, one read at a time
// Map is 0 ID, 1 event count, 2 status, 3 reads served before this
// Unmapped addresses return zero data with err set
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

`include "sync_macros.svh"

module status_regs
    import sync_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_in,
    input  logic    evt_pulse,
    input  data_t   status_in,
    input  logic    req_ack,
    input  addr_t   req_addr,
    input  logic    rsp_rdy,
    output logic    rsp_req,
    output rd_rsp_t rsp
);

    data_t   evt_cnt;
    data_t   status_q;
    data_t   read_cnt;
    logic    rsp_pend;
    rd_rsp_t rsp_next;

    // Count cycles with evt_pulse high
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            evt_cnt <= '0;
        end else if (evt_pulse) begin
            evt_cnt <= evt_cnt + 1'b1;
        end
    end

    // Status snapshot, refreshed every cycle
    always_ff @(posedge clk_in) begin
        status_q <= status_in;
    end

    // Address decode
    always_comb begin
        rsp_next.err = (req_addr >= addr_t'(`SYNC_NUM_REGS));
        case (req_addr)
            addr_t'(0): rsp_next.data = `SYNC_REG_ID;
            addr_t'(1): rsp_next.data = evt_cnt;
            addr_t'(2): rsp_next.data = status_q;
            // Count before this read is added
            addr_t'(3): rsp_next.data = read_cnt;
            default:    rsp_next.data = '0;
        endcase
    end

    // Served reads and pending response
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            read_cnt <= '0;
            rsp_pend <= 1'b0;
        end else if (req_ack) begin
            read_cnt <= read_cnt + 1'b1;
            rsp_pend <= 1'b1;
        end else if (rsp_req) begin
            rsp_pend <= 1'b0;
        end
    end

    // Response payload, loaded on the request
    always_ff @(posedge clk_in) begin
        if (req_ack) begin
            rsp <= rsp_next;
        end
    end

    // Normally the cycle after the ack, later if the return path is busy
    assign rsp_req = rsp_pend && rsp_rdy;

    // Host keeps one read in flight, so a new request finds no response waiting
    one_outstanding: assert property (
        @(posedge clk_in) disable iff (rst_in) req_ack |-> !rsp_pend
    ) else $error("status_regs: request arrived with a response pending");

endmodule : status_regs

`default_nettype wire

// ==== src/sync/sync_bus.sv ====
// ==================================================================
// Payload crossing for infrequent transfers, such as register reads
// One transfer in flight, req_in honored only while rdy_in is high
// data_out is valid in the cycle ack_out pulses and holds after
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

module sync_bus
    import sync_pkg::*;
#(
    parameter type             T              = logic,
    parameter T                RST_VALUE      = '0,
    parameter handshake_mode_t HANDSHAKE_MODE = HANDSHAKE_MODE_4PHASE
) (
    // Source domain
    input  logic clk_in,
    input  logic rst_in,
    input  logic req_in,
    input  T     data_in,
    output logic rdy_in,
    // Destination domain
    input  logic clk_out,
    input  logic rst_out,
    output logic ack_out,
    output T     data_out
);

    // Source-side hold register, stable while the event crosses
    T     data_src;
    // Synchronized event, one destination cycle wide
    logic evt_dst;

    // Capture on an accepted request
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            data_src <= RST_VALUE;
        end else if (req_in && rdy_in) begin
            data_src <= data_in;
        end
    end

    // Handshake, request out and acknowledge back
    sync_event #(
        .MODE    (HANDSHAKE_MODE)
    ) evt_sync0 (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .evt_in  (req_in),
        .rdy_in  (rdy_in),
        .clk_out (clk_out),
        .rst_out (rst_out),
        .evt_out (evt_dst)
    );

    // Destination capture, source is quiet at this point
    always_ff @(posedge clk_out) begin
        if (rst_out) begin
            data_out <= RST_VALUE;
        end else if (evt_dst) begin
            data_out <= data_src;
        end
    end

    // ack_out lines up with the captured data
    always_ff @(posedge clk_out) begin
        if (rst_out) begin
            ack_out <= 1'b0;
        end else begin
            ack_out <= evt_dst;
        end
    end

    // Source stays busy until the destination has captured the payload
    src_hold_stable: assert property (
        @(posedge clk_out) disable iff (rst_out) evt_dst |-> !rdy_in
    ) else $error("sync_bus: source re-armed before the destination capture");

endmodule : sync_bus

`default_nettype wire

// ==== src/sync/sync_event.sv ====
// ==================================================================
// Single event crossing with a two-way handshake
// evt_in is taken only while rdy_in is high
// 2-phase re-arms after one return trip, 4-phase after two
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

module sync_event
    import sync_pkg::*;
#(
    parameter handshake_mode_t MODE = HANDSHAKE_MODE_4PHASE
) (
    // Source domain
    input  logic clk_in,
    input  logic rst_in,
    input  logic evt_in,
    output logic rdy_in,
    // Destination domain
    input  logic clk_out,
    input  logic rst_out,
    output logic evt_out
);

    // Request level, toggles in 2-phase, pulses high in 4-phase
    logic req_lvl;
    logic accept;

    // Request into the destination domain
    (* ASYNC_REG = "TRUE" *) logic [1:0] req_sync;
    // Previous synced request, also the returned acknowledge
    logic req_sync_q;

    // Acknowledge back into the source domain
    (* ASYNC_REG = "TRUE" *) logic [1:0] ack_sync;

    assign accept = evt_in && rdy_in;

    // Source side request level
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            req_lvl <= 1'b0;
        end else if (MODE == HANDSHAKE_MODE_2PHASE) begin
            if (accept) begin
                req_lvl <= ~req_lvl;
            end
        end else begin
            // Drop the level once the ack has come back high
            if (accept) begin
                req_lvl <= 1'b1;
            end else if (ack_sync[1]) begin
                req_lvl <= 1'b0;
            end
        end
    end

    // Two-flop chain into the destination
    always_ff @(posedge clk_out) begin
        if (rst_out) begin
            req_sync   <= 2'b00;
            req_sync_q <= 1'b0;
        end else begin
            req_sync   <= {req_sync[0], req_lvl};
            req_sync_q <= req_sync[1];
        end
    end

    // Edge detect, any edge in 2-phase, rising edge in 4-phase
    always_comb begin
        if (MODE == HANDSHAKE_MODE_2PHASE) begin
            evt_out = req_sync[1] ^ req_sync_q;
        end else begin
            evt_out = req_sync[1] & ~req_sync_q;
        end
    end

    // Ack returns from req_sync_q, so it trails the destination capture
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ack_sync <= 2'b00;
        end else begin
            ack_sync <= {ack_sync[0], req_sync_q};
        end
    end

    // Ready once the acknowledge matches the request
    always_comb begin
        if (MODE == HANDSHAKE_MODE_2PHASE) begin
            rdy_in = (ack_sync[1] == req_lvl);
        end else begin
            rdy_in = !req_lvl && !ack_sync[1];
        end
    end

    // Caller must wait for rdy_in, an early event would be lost
    evt_in_while_busy: assert property (
        @(posedge clk_in) disable iff (rst_in) evt_in |-> rdy_in
    ) else $error("sync_event: evt_in raised while rdy_in is low");

endmodule : sync_event

`default_nettype wire

// ==== common/axil_rd_if.sv ====
// ==================================================================
// AXI4-Lite read channels only, no write side
// Lives in the clk_out domain, clock and reset stay outside
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

interface axil_rd_if
    import sync_pkg::*;
();

    // Read address channel
    addr_t      araddr;
    logic       arvalid;
    logic       arready;

    // Read data channel
    data_t      rdata;
    axil_resp_t rresp;
    logic       rvalid;
    logic       rready;

    // Host side
    modport master (
        output araddr, arvalid, rready,
        input  arready, rdata, rresp, rvalid
    );

    // Register side
    modport slave (
        input  araddr, arvalid, rready,
        output arready, rdata, rresp, rvalid
    );

endinterface : axil_rd_if

`default_nettype wire

// ==== common/sync_pkg.sv ====
// ==================================================================
// Shared types of the CDC register reader
// Widths come from sync_macros.svh
// ==================================================================
`default_nettype none

`include "sync_macros.svh"

package sync_pkg;

    // Toggle per event, or full level up/down per event
    typedef enum logic {
        HANDSHAKE_MODE_2PHASE = 1'b0,
        HANDSHAKE_MODE_4PHASE = 1'b1
    } handshake_mode_t;

    // Register word address
    typedef logic [`SYNC_ADDR_WID-1:0] addr_t;

    // Register data
    typedef logic [`SYNC_DATA_WID-1:0] data_t;

    // Read response from the register block
    typedef struct packed {
        data_t data;
        logic  err;
    } rd_rsp_t;

    // AXI4-Lite response codes in use
    typedef enum logic [1:0] {
        AXIL_RESP_OKAY   = 2'b00,
        AXIL_RESP_SLVERR = 2'b10
    } axil_resp_t;

endpackage : sync_pkg

`default_nettype wire

// ==== common/sync_macros.svh ====
// ==================================================================
// Build-wide sizes and the handshake mode of both crossings
// SYNC_HANDSHAKE_MODE names a sync_pkg literal, so import sync_pkg
// ==================================================================
`ifndef SYNC_MACROS_SVH
`define SYNC_MACROS_SVH

// Register word address width
`define SYNC_ADDR_WID 4

// Register data width
`define SYNC_DATA_WID 32

// Registers mapped from address 0 upward
`define SYNC_NUM_REGS 4

// Fixed value returned by register 0
`define SYNC_REG_ID 32'hCDC0_5A71

// Handshake mode of this build
`define SYNC_HANDSHAKE_MODE HANDSHAKE_MODE_4PHASE

`endif
